/* common/pcw_defs.svh */
// PCW system control constants for bus widths, I/O port numbers and register reset values
`ifndef PCW_DEFS_SVH
`define PCW_DEFS_SVH

// Bus and memory widths
`define PCW_ADDR_W        16
`define PCW_RAM_ADDR_W    18
`define PCW_DATA_W        8
`define PCW_PAGE_OFS_W    14
`define PCW_MISS_W        4

// Cycles from a port F4 read to the timer clear
`define PCW_TCLR_CYCLES   32

// Control port numbers on the low address byte
`define PCW_PORT_PAGE0    8'hF0
`define PCW_PORT_PAGE1    8'hF1
`define PCW_PORT_PAGE2    8'hF2
`define PCW_PORT_PAGE3    8'hF3
`define PCW_PORT_LOCK     8'hF4
`define PCW_PORT_ROLLER   8'hF5
`define PCW_PORT_SCROLL   8'hF6
`define PCW_PORT_INVERSE  8'hF7
`define PCW_PORT_SYSCTL   8'hF8
// Same address as the lock port, read side
`define PCW_PORT_TIMER    8'hF4

// Reset values, native paging with banks 0 to 3
`define PCW_PAGE0_RESET   8'h80
`define PCW_PAGE1_RESET   8'h81
`define PCW_PAGE2_RESET   8'h82
`define PCW_PAGE3_RESET   8'h83
`define PCW_LOCK_RESET    8'hF1
`define PCW_INV_RESET     8'h80

// Value on the bus for ports nobody answers
`define PCW_IDLE_DATA     8'hFF

`endif

/* common/pcw_bus_pkg.sv */
// CPU bus types for the PCW system control block: bus cycle, port and command codes
`include "pcw_defs.svh"

package pcw_bus_pkg;

    // One CPU cycle, strobes active high
    typedef struct packed {
        logic [`PCW_ADDR_W-1:0] addr;
        logic [`PCW_DATA_W-1:0] wdata;
        logic                   io_rd;
        logic                   io_wr;
        logic                   mem_wr;
    } cpu_bus_t;

    // Decoded control ports
    typedef enum logic [3:0] {
        PAGE0,
        PAGE1,
        PAGE2,
        PAGE3,
        LOCK,
        ROLLER,
        SCROLL,
        INVERSE,
        SYSCTL,
        TIMER_STAT,
        NONE
    } io_port_e;

    // System control commands, low nibble of a port F8 write
    typedef enum logic [3:0] {
        NOP       = 4'd0,
        DISK_NMI  = 4'd2,
        DISK_INT  = 4'd3,
        DISK_OFF  = 4'd4,
        TC_SET    = 4'd5,
        TC_CLR    = 4'd6,
        MOTOR_ON  = 4'd9,
        MOTOR_OFF = 4'd10,
        SPK_ON    = 4'd11,
        SPK_OFF   = 4'd12
    } sys_cmd_e;

    // Decode result for the execute stages
    typedef struct packed {
        io_port_e wr_port;
        logic     stat_rd;
        logic     tclr_start;
        logic     cmd_valid;
        sys_cmd_e cmd;
    } io_sel_t;

endpackage

/* common/pcw_ctrl_pkg.sv */
// Control state types for the PCW system control block: paging, video and disk control
`include "pcw_defs.svh"

package pcw_ctrl_pkg;

    // Ports F0 to F3 plus the CPC read lock in F4
    typedef struct packed {
        logic [3:0][`PCW_DATA_W-1:0] page;
        logic [`PCW_DATA_W-1:0]      lock;
    } page_regs_t;

    // Display controls from ports F5 to F7
    typedef struct packed {
        logic [`PCW_DATA_W-1:0] roller_ptr;
        logic [`PCW_DATA_W-1:0] y_scroll;
        logic                   inverse;
        logic                   disable_vid;
    } video_ctrl_t;

    // Disk and speaker controls set by port F8 commands
    typedef struct packed {
        logic fdc_tc;
        logic motor_on;
        logic speaker_on;
        logic disk_to_nmi;
        logic disk_to_int;
    } disk_ctrl_t;

    // Timer clear sequencer after a port F4 read
    typedef enum logic {
        IDLE,
        CLEARING
    } irq_state_e;

endpackage

/* verilog/pcw_io_decode.sv */
// PCW I/O decode, turns CPU strobes and the low address byte into port selects and commands
`timescale 1ns/1ps
`include "pcw_defs.svh"

module pcw_io_decode
(
    input  pcw_bus_pkg::cpu_bus_t bus,
    output pcw_bus_pkg::io_sel_t  sel
);
    import pcw_bus_pkg::*;

    logic [`PCW_DATA_W-1:0] port_lo;

    // Only the low address byte selects an I/O port
    assign port_lo = bus.addr[`PCW_DATA_W-1:0];

    always_comb
    begin
        sel = '{wr_port: NONE, stat_rd: 1'b0, tclr_start: 1'b0, cmd_valid: 1'b0, cmd: NOP};

        if (bus.io_wr)
        begin
            case (port_lo)
                `PCW_PORT_PAGE0:   sel.wr_port = PAGE0;
                `PCW_PORT_PAGE1:   sel.wr_port = PAGE1;
                `PCW_PORT_PAGE2:   sel.wr_port = PAGE2;
                `PCW_PORT_PAGE3:   sel.wr_port = PAGE3;
                `PCW_PORT_LOCK:    sel.wr_port = LOCK;
                `PCW_PORT_ROLLER:  sel.wr_port = ROLLER;
                `PCW_PORT_SCROLL:  sel.wr_port = SCROLL;
                `PCW_PORT_INVERSE: sel.wr_port = INVERSE;
                `PCW_PORT_SYSCTL:  sel.wr_port = SYSCTL;
                default:           sel.wr_port = NONE;
            endcase

            // System control command in the low nibble
            if (port_lo == `PCW_PORT_SYSCTL)
            begin
                sel.cmd_valid = 1'b1;
                case (bus.wdata[3:0])
                    4'd2, 4'd3, 4'd4, 4'd5, 4'd6,
                    4'd9, 4'd10, 4'd11, 4'd12:
                        sel.cmd = sys_cmd_e'(bus.wdata[3:0]);
                    // Bootstrap end, reset and unknown codes do nothing here
                    default:
                        sel.cmd = NOP;
                endcase
            end
        end

        if (bus.io_rd)
        begin
            // F8 and F4 both return the status byte
            sel.stat_rd    = (port_lo == `PCW_PORT_SYSCTL) || (port_lo == `PCW_PORT_TIMER);
            // F4 read also clears the timer misses
            sel.tclr_start = (port_lo == `PCW_PORT_TIMER);
        end
    end

endmodule

/* verilog/pcw_memory_map.sv */
// PCW memory map, holds ports F0 to F7 and maps CPU addresses into the 256K RAM
`timescale 1ns/1ps
`include "pcw_defs.svh"

module pcw_memory_map
(
    input  logic                            clk_sys,
    input  logic                            reset,
    input  pcw_bus_pkg::cpu_bus_t           bus,
    input  pcw_bus_pkg::io_sel_t            sel,
    output logic [`PCW_RAM_ADDR_W-1:0]      ram_addr,
    output pcw_ctrl_pkg::video_ctrl_t       video
);
    import pcw_bus_pkg::*;
    import pcw_ctrl_pkg::*;

    page_regs_t             pages;
    logic [`PCW_DATA_W-1:0] roller;
    logic [`PCW_DATA_W-1:0] scroll;
    logic [`PCW_DATA_W-1:0] vid_flags;

    logic [1:0]                  bank;
    logic [`PCW_DATA_W-1:0]      page_byte;
    logic                        lock_bit;
    logic [2:0]                  cpc_block;
    logic [`PCW_PAGE_OFS_W-1:0]  offset;

    // Port writes, one register per port
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            pages.page[0] <= `PCW_PAGE0_RESET;
            pages.page[1] <= `PCW_PAGE1_RESET;
            pages.page[2] <= `PCW_PAGE2_RESET;
            pages.page[3] <= `PCW_PAGE3_RESET;
            pages.lock    <= `PCW_LOCK_RESET;
            roller        <= '0;
            scroll        <= '0;
            vid_flags     <= `PCW_INV_RESET;
        end
        else
        begin
            case (sel.wr_port)
                PAGE0:   pages.page[0] <= bus.wdata;
                PAGE1:   pages.page[1] <= bus.wdata;
                PAGE2:   pages.page[2] <= bus.wdata;
                PAGE3:   pages.page[3] <= bus.wdata;
                LOCK:    pages.lock    <= bus.wdata;
                ROLLER:  roller        <= bus.wdata;
                SCROLL:  scroll        <= bus.wdata;
                INVERSE: vid_flags     <= bus.wdata;
                default: ;
            endcase
        end
    end

    // Top two address bits pick the 16K bank
    assign bank      = bus.addr[`PCW_ADDR_W-1:`PCW_PAGE_OFS_W];
    assign offset    = bus.addr[`PCW_PAGE_OFS_W-1:0];
    assign page_byte = pages.page[bank];
    // Lock bits 7:4 belong to banks 3:0
    assign lock_bit  = pages.lock[{1'b1, bank}];

    always_comb
    begin
        // CPC mode, writes always use the low field
        if (bus.mem_wr || lock_bit)
            cpc_block = page_byte[2:0];
        else
            cpc_block = page_byte[6:4];

        // Bit 7 set means native PCW paging, 16 blocks
        if (page_byte[7])
            ram_addr = {page_byte[3:0], offset};
        else
            ram_addr = {1'b0, cpc_block, offset};
    end

    // Display controls
    assign video.roller_ptr  = roller;
    assign video.y_scroll    = scroll;
    assign video.inverse     = vid_flags[7];
    // F7 bit 6 enables the display
    assign video.disable_vid = ~vid_flags[6];

endmodule

/* verilog/pcw_interrupt_ctrl.sv */
// PCW interrupt control, runs F8 commands, disk IRQ routing, timer misses and INT/NMI lines
`timescale 1ns/1ps
`include "pcw_defs.svh"

module pcw_interrupt_ctrl
(
    input  logic                          clk_sys,
    input  logic                          reset,
    input  pcw_bus_pkg::io_sel_t          sel,
    input  logic                          timer_tick,
    input  logic                          fdc_int,
    input  logic                          cpu_iff1,
    output pcw_ctrl_pkg::disk_ctrl_t      disk,
    output logic [`PCW_MISS_W-1:0]        misses,
    output logic                          fdc_latch,
    output logic                          int_req,
    output logic                          nmi_req
);
    import pcw_bus_pkg::*;
    import pcw_ctrl_pkg::*;

    localparam int TCLR_W = $clog2(`PCW_TCLR_CYCLES);

    logic              mode_chg;
    logic [1:0]        tick_sr;
    logic [1:0]        fdc_sr;
    logic              tick_pe;
    logic              fdc_pe;
    logic              fdc_ne;
    logic              nmi_flag;
    logic              timer_line;
    logic              int_line;
    logic              nmi_line;
    irq_state_e        tclr_state;
    logic [TCLR_W-1:0] tclr_cnt;

    // Commands from port F8
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            disk     <= '0;
            mode_chg <= 1'b0;
        end
        else
        begin
            mode_chg <= 1'b0;
            if (sel.cmd_valid)
            begin
                case (sel.cmd)
                    DISK_NMI:
                    begin
                        disk.disk_to_nmi <= 1'b1;
                        disk.disk_to_int <= 1'b0;
                    end
                    DISK_INT:
                    begin
                        disk.disk_to_nmi <= 1'b0;
                        disk.disk_to_int <= 1'b1;
                        mode_chg         <= 1'b1;
                    end
                    DISK_OFF:
                    begin
                        disk.disk_to_nmi <= 1'b0;
                        disk.disk_to_int <= 1'b0;
                        mode_chg         <= 1'b1;
                    end
                    TC_SET:    disk.fdc_tc     <= 1'b1;
                    TC_CLR:    disk.fdc_tc     <= 1'b0;
                    MOTOR_ON:  disk.motor_on   <= 1'b1;
                    MOTOR_OFF: disk.motor_on   <= 1'b0;
                    SPK_ON:    disk.speaker_on <= 1'b1;
                    SPK_OFF:   disk.speaker_on <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    // Input sample register, edges seen one cycle later
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            tick_sr <= '0;
            fdc_sr  <= '0;
        end
        else
        begin
            tick_sr <= {tick_sr[0], timer_tick};
            fdc_sr  <= {fdc_sr[0], fdc_int};
        end
    end

    assign tick_pe = tick_sr[0] & ~tick_sr[1];
    assign fdc_pe  = fdc_sr[0] & ~fdc_sr[1];
    assign fdc_ne  = ~fdc_sr[0] & fdc_sr[1];

    // Floppy status latch and pending NMI
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            fdc_latch <= 1'b0;
            nmi_flag  <= 1'b0;
        end
        else
        begin
            if (fdc_pe)
            begin
                fdc_latch <= 1'b1;
                if (disk.disk_to_nmi)
                    nmi_flag <= 1'b1;
            end
            else if (fdc_ne)
                fdc_latch <= 1'b0;
            // Routing away from NMI drops a pending one
            if (mode_chg && !disk.disk_to_nmi)
                nmi_flag <= 1'b0;
        end
    end

    // Timer tick, clear sequence and request lines
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            misses     <= '0;
            timer_line <= 1'b0;
            int_line   <= 1'b0;
            nmi_line   <= 1'b0;
            tclr_state <= IDLE;
            tclr_cnt   <= '0;
        end
        else
        begin
            if (tick_pe)
            begin
                // Saturates at 15
                if (misses != '1)
                    misses <= misses + 1'b1;
                timer_line <= cpu_iff1;
                nmi_line   <= nmi_flag;
                int_line   <= disk.disk_to_int & fdc_latch & cpu_iff1;
            end

            case (tclr_state)
                IDLE:
                begin
                    if (sel.tclr_start)
                    begin
                        tclr_state <= CLEARING;
                        tclr_cnt   <= '0;
                    end
                end
                CLEARING:
                begin
                    if (tclr_cnt == TCLR_W'(`PCW_TCLR_CYCLES - 1))
                    begin
                        tclr_state <= IDLE;
                        timer_line <= 1'b0;
                        misses     <= '0;
                    end
                    else
                        tclr_cnt <= tclr_cnt + 1'b1;
                end
                default: tclr_state <= IDLE;
            endcase

            // Routing away from INT drops the disk INT line
            if (mode_chg && !disk.disk_to_int)
                int_line <= 1'b0;
        end
    end

    assign int_req = int_line | timer_line;
    assign nmi_req = nmi_line;

endmodule

/* verilog/pcw_read_mux.sv */
// PCW read mux, builds the F8/F4 status byte and returns I/O read data
`timescale 1ns/1ps
`include "pcw_defs.svh"

module pcw_read_mux
(
    input  pcw_bus_pkg::io_sel_t          sel,
    input  logic [`PCW_MISS_W-1:0]        misses,
    input  logic                          fdc_latch,
    input  logic                          vblank,
    input  logic                          ntsc,
    output logic [`PCW_DATA_W-1:0]        rdata
);

    logic [`PCW_DATA_W-1:0] status;

    // Bit 7 unused
    // Bit 6 flyback, bit 5 floppy interrupt latch
    // Bit 4 low for 60 Hz, bits 3:0 timer misses
    assign status = {1'b0, vblank, fdc_latch, ~ntsc, misses};

    always_comb
    begin
        if (sel.stat_rd)
            rdata = status;
        else
            rdata = `PCW_IDLE_DATA;
    end

endmodule

/* verilog/pcw_sys_ctrl.sv */
// PCW system control top, I/O decode, memory map, interrupt control and read data
`timescale 1ns/1ps
`include "pcw_defs.svh"

module pcw_sys_ctrl
(
    input  logic                          clk_sys,
    input  logic                          reset,
    input  pcw_bus_pkg::cpu_bus_t         bus,
    input  logic                          timer_tick,
    input  logic                          fdc_int,
    input  logic                          cpu_iff1,
    input  logic                          vblank,
    input  logic                          ntsc,
    output logic [`PCW_RAM_ADDR_W-1:0]    ram_addr,
    output logic [`PCW_DATA_W-1:0]        rdata,
    output pcw_ctrl_pkg::video_ctrl_t     video,
    output pcw_ctrl_pkg::disk_ctrl_t      disk,
    output logic                          int_req,
    output logic                          nmi_req
);
    import pcw_bus_pkg::*;

    io_sel_t                 sel;
    logic [`PCW_MISS_W-1:0]  misses;
    logic                    fdc_latch;

    pcw_io_decode decode_i
    (
        .bus (bus),
        .sel (sel)
    );

    // Also owns the video ports F5 to F7
    pcw_memory_map mem_map_i
    (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .bus      (bus),
        .sel      (sel),
        .ram_addr (ram_addr),
        .video    (video)
    );

    pcw_interrupt_ctrl irq_i
    (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .sel        (sel),
        .timer_tick (timer_tick),
        .fdc_int    (fdc_int),
        .cpu_iff1   (cpu_iff1),
        .disk       (disk),
        .misses     (misses),
        .fdc_latch  (fdc_latch),
        .int_req    (int_req),
        .nmi_req    (nmi_req)
    );

    pcw_read_mux read_mux_i
    (
        .sel       (sel),
        .misses    (misses),
        .fdc_latch (fdc_latch),
        .vblank    (vblank),
        .ntsc      (ntsc),
        .rdata     (rdata)
    );

endmodule

/* tests/pcw_sys_ctrl_props.sv */
// PCW system control assertions for reset, timer miss saturation and CPC address range
`timescale 1ns/1ps
`include "pcw_defs.svh"

module pcw_sys_ctrl_props
(
    input logic                       clk_sys,
    input logic                       reset,
    input logic                       int_req,
    input logic                       nmi_req,
    input logic [`PCW_MISS_W-1:0]     misses,
    input logic [`PCW_RAM_ADDR_W-1:0] ram_addr,
    input logic [1:0]                 bank,
    input pcw_ctrl_pkg::page_regs_t   pages,
    input pcw_ctrl_pkg::irq_state_e   tclr_state
);
    import pcw_ctrl_pkg::*;

    logic page_b7;

    // Mode bit of the page register for the bank on the bus
    assign page_b7 = pages.page[bank][7];

    // Request lines quiet right after reset
    a_reset_quiet: assert property (@(posedge clk_sys) $past(reset) |-> !int_req && !nmi_req)
        else $error("request line high after reset");

    // 15 to 0 only at the end of a clear sequence
    a_no_wrap: assert property (@(posedge clk_sys) disable iff (reset)
        (!$past(reset) && $past(misses) == 4'hF && misses == 4'h0) |-> $past(tclr_state) == CLEARING)
        else $error("timer misses wrapped without a clear");

    // CPC pages stay in the low 128K
    a_cpc_low: assert property (@(posedge clk_sys) disable iff (reset) !page_b7 |-> !ram_addr[17])
        else $error("CPC page mapped above 128K");

endmodule

bind pcw_sys_ctrl pcw_sys_ctrl_props props_i
(
    .clk_sys    (clk_sys),
    .reset      (reset),
    .int_req    (int_req),
    .nmi_req    (nmi_req),
    .misses     (misses),
    .ram_addr   (ram_addr),
    .bank       (bus.addr[`PCW_ADDR_W-1:`PCW_PAGE_OFS_W]),
    .pages      (mem_map_i.pages),
    .tclr_state (irq_i.tclr_state)
);

/* tests/tb_pcw_sys_ctrl.sv */
// Table driven testbench for the PCW system control block covering paging, commands, timer and disk IRQs
`timescale 1ns/1ps
`include "pcw_defs.svh"

module tb_pcw_sys_ctrl;
    import pcw_bus_pkg::*;
    import pcw_ctrl_pkg::*;

    localparam int NROWS  = 39;
    localparam int SETTLE = 40;
    // Check mask bits
    localparam logic [5:0] C_RD  = 6'b000001;
    localparam logic [5:0] C_RA  = 6'b000010;
    localparam logic [5:0] C_INT = 6'b000100;
    localparam logic [5:0] C_NMI = 6'b001000;
    localparam logic [5:0] C_DSK = 6'b010000;
    localparam logic [5:0] C_VID = 6'b100000;

    typedef enum logic [2:0] {
        IO_WR, IO_RD, MEM_RD, MEM_WR, TICK, FDC_RISE, FDC_FALL, SET_IFF
    } kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [5:0]  chk;
        logic [7:0]  exp_rd;
        logic [17:0] exp_ra;
        logic        exp_int;
        logic        exp_nmi;
        logic [4:0]  exp_disk;
        logic [17:0] exp_vid;
    } row_t;

    logic        clk_sys;
    logic        reset;
    cpu_bus_t    bus;
    logic        timer_tick;
    logic        fdc_int;
    logic        cpu_iff1;
    logic        vblank;
    logic        ntsc;
    logic [17:0] ram_addr;
    logic [7:0]  rdata;
    video_ctrl_t video;
    disk_ctrl_t  disk;
    logic        int_req;
    logic        nmi_req;

    row_t rows [NROWS];
    int   nrow;
    int   errors;

    pcw_sys_ctrl dut_i
    (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .bus        (bus),
        .timer_tick (timer_tick),
        .fdc_int    (fdc_int),
        .cpu_iff1   (cpu_iff1),
        .vblank     (vblank),
        .ntsc       (ntsc),
        .ram_addr   (ram_addr),
        .rdata      (rdata),
        .video      (video),
        .disk       (disk),
        .int_req    (int_req),
        .nmi_req    (nmi_req)
    );

    // 20 ns clock
    always #10 clk_sys = ~clk_sys;

    // Watchdog allows 60 cycles per row
    initial
    begin
        #(NROWS * 60 * 20);
        $display("Watchdog timeout, the table did not finish in time");
        $display("Done: errors found");
        $finish;
    end

    task automatic add_row(input kind_e k, input logic [15:0] a, input logic [7:0] d,
                           input logic [5:0] c, input logic [7:0] rd, input logic [17:0] ra,
                           input logic ir, input logic nr, input logic [4:0] dk,
                           input logic [17:0] vd);
        rows[nrow] = '{k, a, d, c, rd, ra, ir, nr, dk, vd};
        nrow++;
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk_sys);
        #2;
        bus.addr = r.addr;
        bus.wdata = r.data;
        case (r.kind)
            IO_WR:
            begin
                bus.io_wr = 1'b1;
                @(posedge clk_sys);
                #2;
                bus.io_wr = 1'b0;
            end
            IO_RD:
            begin
                bus.io_rd = 1'b1;
                // Data bits 6 and 4 of a read row drive vblank and ntsc
                vblank = r.data[6];
                ntsc = r.data[4];
            end
            MEM_WR:   bus.mem_wr = 1'b1;
            TICK:
            begin
                // One pulse per count with two low cycles between
                for (int k = 0; k < int'(r.data); k++)
                begin
                    timer_tick = 1'b1;
                    @(posedge clk_sys);
                    #2;
                    timer_tick = 1'b0;
                    repeat (2) @(posedge clk_sys);
                    #2;
                end
            end
            FDC_RISE: fdc_int = 1'b1;
            FDC_FALL: fdc_int = 1'b0;
            SET_IFF:  cpu_iff1 = r.data[0];
            default: ;
        endcase
        repeat (SETTLE) @(posedge clk_sys);
        // Sample mid cycle
        #5;
    endtask

    task automatic check_row(input int idx, input row_t r);
        if (r.chk[0] && rdata !== r.exp_rd)
        begin
            errors++;
            $display("ERR %0t row %0d rdata exp %h got %h", $time, idx, r.exp_rd, rdata);
        end
        if (r.chk[1] && ram_addr !== r.exp_ra)
        begin
            errors++;
            $display("ERR %0t row %0d ram_addr exp %h got %h", $time, idx, r.exp_ra, ram_addr);
        end
        if (r.chk[2] && int_req !== r.exp_int)
        begin
            errors++;
            $display("ERR %0t row %0d int_req exp %b got %b", $time, idx, r.exp_int, int_req);
        end
        if (r.chk[3] && nmi_req !== r.exp_nmi)
        begin
            errors++;
            $display("ERR %0t row %0d nmi_req exp %b got %b", $time, idx, r.exp_nmi, nmi_req);
        end
        if (r.chk[4] && disk !== r.exp_disk)
        begin
            errors++;
            $display("ERR %0t row %0d disk exp %h got %h", $time, idx, r.exp_disk, disk);
        end
        if (r.chk[5] && video !== r.exp_vid)
        begin
            errors++;
            $display("ERR %0t row %0d video exp %h got %h", $time, idx, r.exp_vid, video);
        end
    endtask

    initial
    begin
        clk_sys = 1'b0;
        reset = 1'b1;
        bus = '0;
        timer_tick = 1'b0;
        fdc_int = 1'b0;
        cpu_iff1 = 1'b0;
        vblank = 1'b0;
        ntsc = 1'b1;
        nrow = 0;
        errors = 0;

        // Reset map is native banks 0 to 3
        add_row(MEM_RD, 16'h0000, 8'h00, 6'h3F, 8'hFF, 18'h00000, 0, 0, 5'h00, 18'h00003);
        add_row(MEM_RD, 16'h4000, 8'h00, 6'h3F, 8'hFF, 18'h04000, 0, 0, 5'h00, 18'h00003);
        add_row(MEM_RD, 16'h8000, 8'h00, 6'h3F, 8'hFF, 18'h08000, 0, 0, 5'h00, 18'h00003);
        add_row(MEM_RD, 16'hC000, 8'h00, 6'h3F, 8'hFF, 18'h0C000, 0, 0, 5'h00, 18'h00003);
        // Native block 10 in bank 1
        add_row(IO_WR, 16'h00F1, 8'h8A, C_RD | C_INT | C_NMI, 8'hFF, 0, 0, 0, 0, 0);
        add_row(MEM_RD, 16'h4123, 8'h00, C_RD | C_RA, 8'hFF, 18'h28123, 0, 0, 0, 0);
        add_row(MEM_WR, 16'h4123, 8'h00, C_RA, 8'hFF, 18'h28123, 0, 0, 0, 0);
        // CPC page in bank 2 with read field 3 and write field 1
        add_row(IO_WR, 16'h00F2, 8'h31, C_RD, 8'hFF, 0, 0, 0, 0, 0);
        add_row(IO_WR, 16'h00F4, 8'h00, C_RD, 8'hFF, 0, 0, 0, 0, 0);
        add_row(MEM_RD, 16'h8005, 8'h00, C_RA, 8'hFF, 18'h0C005, 0, 0, 0, 0);
        add_row(MEM_WR, 16'h8005, 8'h00, C_RA, 8'hFF, 18'h04005, 0, 0, 0, 0);
        // Lock bit 6 forces reads onto the write field
        add_row(IO_WR, 16'h00F4, 8'h40, C_RD, 8'hFF, 0, 0, 0, 0, 0);
        add_row(MEM_RD, 16'h8005, 8'h00, C_RA, 8'hFF, 18'h04005, 0, 0, 0, 0);
        // Commands for tc, motor and speaker
        add_row(IO_WR, 16'h00F8, 8'h05, C_DSK | C_INT, 8'hFF, 0, 0, 0, 5'h10, 0);
        add_row(IO_WR, 16'h00F8, 8'h09, C_DSK, 8'hFF, 0, 0, 0, 5'h18, 0);
        add_row(IO_WR, 16'h00F8, 8'h0B, C_DSK, 8'hFF, 0, 0, 0, 5'h1C, 0);
        add_row(IO_WR, 16'h00F8, 8'h06, C_DSK, 8'hFF, 0, 0, 0, 5'h0C, 0);
        add_row(IO_WR, 16'h00F8, 8'h0A, C_DSK, 8'hFF, 0, 0, 0, 5'h04, 0);
        add_row(IO_WR, 16'h00F8, 8'h0C, C_DSK | C_NMI, 8'hFF, 0, 0, 0, 5'h00, 0);
        // Roller, scroll, then display on with normal video
        add_row(IO_WR, 16'h00F5, 8'h12, C_VID, 8'hFF, 0, 0, 0, 0, 18'h04803);
        add_row(IO_WR, 16'h00F6, 8'h34, C_VID, 8'hFF, 0, 0, 0, 0, 18'h048D3);
        add_row(IO_WR, 16'h00F7, 8'h40, C_VID, 8'hFF, 0, 0, 0, 0, 18'h048D0);
        // Timer ticks with interrupts enabled
        add_row(SET_IFF, 16'h0000, 8'h01, C_INT | C_NMI, 8'hFF, 0, 0, 0, 0, 0);
        add_row(TICK, 16'h0000, 8'd1, C_INT | C_NMI, 8'hFF, 0, 1, 0, 0, 0);
        // Flyback high on 60 Hz video
        add_row(IO_RD, 16'h00F8, 8'h50, C_RD | C_INT, 8'h41, 0, 1, 0, 0, 0);
        add_row(TICK, 16'h0000, 8'd16, C_INT, 8'hFF, 0, 1, 0, 0, 0);
        // 50 Hz video sets status bit 4
        add_row(IO_RD, 16'h00F8, 8'h00, C_RD, 8'h1F, 0, 1, 0, 0, 0);
        add_row(IO_RD, 16'h00F4, 8'h10, C_RD | C_INT | C_NMI, 8'h00, 0, 0, 0, 0, 0);
        // Disk interrupt routed to NMI
        add_row(IO_WR, 16'h00F8, 8'h02, C_DSK | C_INT | C_NMI, 8'hFF, 0, 0, 0, 5'h02, 0);
        add_row(FDC_RISE, 16'h0000, 8'h00, C_NMI, 8'hFF, 0, 0, 0, 0, 0);
        add_row(IO_RD, 16'h00F8, 8'h10, C_RD, 8'h20, 0, 0, 0, 0, 0);
        add_row(TICK, 16'h0000, 8'd1, C_INT | C_NMI, 8'hFF, 0, 1, 1, 0, 0);
        // Routing off drops the pending NMI at the next tick
        add_row(IO_WR, 16'h00F8, 8'h04, C_DSK | C_INT, 8'hFF, 0, 1, 0, 5'h00, 0);
        add_row(TICK, 16'h0000, 8'd1, C_INT | C_NMI, 8'hFF, 0, 1, 0, 0, 0);
        // Disk interrupt routed to INT
        add_row(IO_WR, 16'h00F8, 8'h03, C_DSK, 8'hFF, 0, 0, 0, 5'h01, 0);
        add_row(TICK, 16'h0000, 8'd1, C_INT | C_NMI, 8'hFF, 0, 1, 0, 0, 0);
        // Timer cleared while the disk line holds INT
        add_row(IO_RD, 16'h00F4, 8'h10, C_RD | C_INT, 8'h20, 0, 1, 0, 0, 0);
        add_row(FDC_FALL, 16'h0000, 8'h00, C_RD, 8'hFF, 0, 0, 0, 0, 0);
        add_row(IO_RD, 16'h00F8, 8'h10, C_RD, 8'h00, 0, 0, 0, 0, 0);

        repeat (8) @(posedge clk_sys);
        #2;
        reset = 1'b0;

        for (int i = 0; i < NROWS; i++)
        begin
            apply_row(rows[i]);
            check_row(i, rows[i]);
            bus.io_rd = 1'b0;
            bus.mem_wr = 1'b0;
        end

        $display("Rows applied %0d, errors %0d", NROWS, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* sim.f */
+incdir+common
common/pcw_bus_pkg.sv
common/pcw_ctrl_pkg.sv
verilog/pcw_io_decode.sv
verilog/pcw_memory_map.sv
verilog/pcw_interrupt_ctrl.sv
verilog/pcw_read_mux.sv
verilog/pcw_sys_ctrl.sv
tests/pcw_sys_ctrl_props.sv
tests/tb_pcw_sys_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the PCW system control simulation with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_pcw_sys_ctrl -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out="$(./obj_dir/sim_tb)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Done: no errors"; then
    exit 0
fi
exit 1
